//--- source/riscv_isa_pkg.sv
package riscv_isa_pkg;

    //////////////////////////////////////////////////
    // Architectural widths
    //////////////////////////////////////////////////

    // Data path width, one machine word
    localparam int XLEN = 32;

    // Register select width, wide enough for x0..x31
    localparam int REG_ADDR_W = 5;

    //////////////////////////////////////////////////
    // Major opcodes, instr[6:0]
    //////////////////////////////////////////////////

    // Any value not listed here is an illegal instruction
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // ALU function select for the EX stage
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // Branch condition, NONE is zero so a cleared word never branches
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6,
        BR_JUMP = 3'd7
    } branch_e;

    // Access size, encoded the same as funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'b000,
        MEM_HALF   = 3'b001,
        MEM_WORD   = 3'b010,
        MEM_BYTE_U = 3'b100,
        MEM_HALF_U = 3'b101
    } mem_type_e;

endpackage

//--- source/pipeline_pkg.sv
package pipeline_pkg;

    //////////////////////////////////////////////////
    // Decode control word
    //////////////////////////////////////////////////

    // Driven by the decoder, cleared to all zero for a bubble
    // 29 bits in total
    typedef struct packed {
        logic [riscv_isa_pkg::REG_ADDR_W-1:0] rd;
        logic [riscv_isa_pkg::REG_ADDR_W-1:0] rs1;
        logic [riscv_isa_pkg::REG_ADDR_W-1:0] rs2;
        riscv_isa_pkg::alu_op_e               alu_op;
        // Result goes back to rd
        logic                                 reg_we;
        // Load from data memory
        logic                                 mem_read;
        // Writeback source is memory, not the ALU
        logic                                 mem_to_reg;
        // Operand B is the immediate instead of rs2
        logic                                 b_is_imm;
        riscv_isa_pkg::mem_type_e             mem_type;
        riscv_isa_pkg::branch_e               branch;
    } decode_ctrl_t;

    //////////////////////////////////////////////////
    // Writeback write from the WB stage
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                                 we;
        logic [riscv_isa_pkg::REG_ADDR_W-1:0] addr;
        logic [riscv_isa_pkg::XLEN-1:0]       data;
    } wb_write_t;

    //////////////////////////////////////////////////
    // ID/EX register contents, stage output
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                           valid;
        decode_ctrl_t                   ctrl;
        logic [riscv_isa_pkg::XLEN-1:0] op_a;
        logic [riscv_isa_pkg::XLEN-1:0] op_b;
        logic [riscv_isa_pkg::XLEN-1:0] store_data;
        logic [riscv_isa_pkg::XLEN-1:0] pc_plus4;
        logic                           predicted_taken;
        logic                           illegal;
    } id_ex_t;

endpackage

//--- source/rv32i_decoder.sv
module rv32i_decoder (
    input  logic [riscv_isa_pkg::XLEN-1:0] instr_i,
    output pipeline_pkg::decode_ctrl_t     ctrl_o,
    output logic [riscv_isa_pkg::XLEN-1:0] imm_o,
    output logic                           illegal_o
);

    // ALU function from funct3, alt is instr[30] where it matters
    function automatic riscv_isa_pkg::alu_op_e alu_from_funct(
        input logic [2:0] funct3,
        input logic       alt
    );
        case (funct3)
            3'b000:  return alt ? riscv_isa_pkg::ALU_SUB : riscv_isa_pkg::ALU_ADD;
            3'b001:  return riscv_isa_pkg::ALU_SLL;
            3'b010:  return riscv_isa_pkg::ALU_SLT;
            3'b011:  return riscv_isa_pkg::ALU_SLTU;
            3'b100:  return riscv_isa_pkg::ALU_XOR;
            3'b101:  return alt ? riscv_isa_pkg::ALU_SRA : riscv_isa_pkg::ALU_SRL;
            3'b110:  return riscv_isa_pkg::ALU_OR;
            default: return riscv_isa_pkg::ALU_AND;
        endcase
    endfunction

    riscv_isa_pkg::opcode_e         opcode;
    logic [2:0]                     funct3;
    logic [riscv_isa_pkg::XLEN-1:0] imm_i_type;
    logic [riscv_isa_pkg::XLEN-1:0] imm_s_type;
    logic [riscv_isa_pkg::XLEN-1:0] imm_b_type;
    logic [riscv_isa_pkg::XLEN-1:0] imm_u_type;
    logic [riscv_isa_pkg::XLEN-1:0] imm_j_type;

    assign opcode = riscv_isa_pkg::opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];

    //////////////////////////////////////////////////
    // Immediates, all sign extended from instr[31]
    //////////////////////////////////////////////////

    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};

    //////////////////////////////////////////////////
    // Control word
    //////////////////////////////////////////////////

    always_comb begin
        // Everything defaults to a no-op
        ctrl_o    = '0;
        imm_o     = '0;
        illegal_o = 1'b0;
        case (opcode)
            riscv_isa_pkg::OPC_LUI: begin
                // B carries the upper immediate straight through
                ctrl_o.rd       = instr_i[11:7];
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.alu_op   = riscv_isa_pkg::ALU_PASS_B;
                ctrl_o.b_is_imm = 1'b1;
                imm_o           = imm_u_type;
            end
            riscv_isa_pkg::OPC_AUIPC: begin
                ctrl_o.rd       = instr_i[11:7];
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                imm_o           = imm_u_type;
            end
            riscv_isa_pkg::OPC_JAL: begin
                ctrl_o.rd       = instr_i[11:7];
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.branch   = riscv_isa_pkg::BR_JUMP;
                imm_o           = imm_j_type;
            end
            riscv_isa_pkg::OPC_JALR: begin
                // Target is rs1 + I immediate
                ctrl_o.rd       = instr_i[11:7];
                ctrl_o.rs1      = instr_i[19:15];
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.branch   = riscv_isa_pkg::BR_JUMP;
                imm_o           = imm_i_type;
            end
            riscv_isa_pkg::OPC_BRANCH: begin
                // Compare rs1 against rs2, so B stays on the register
                ctrl_o.rs1    = instr_i[19:15];
                ctrl_o.rs2    = instr_i[24:20];
                ctrl_o.alu_op = riscv_isa_pkg::ALU_SUB;
                imm_o         = imm_b_type;
                case (funct3)
                    3'b000:  ctrl_o.branch = riscv_isa_pkg::BR_EQ;
                    3'b001:  ctrl_o.branch = riscv_isa_pkg::BR_NE;
                    3'b100:  ctrl_o.branch = riscv_isa_pkg::BR_LT;
                    3'b101:  ctrl_o.branch = riscv_isa_pkg::BR_GE;
                    3'b110:  ctrl_o.branch = riscv_isa_pkg::BR_LTU;
                    3'b111:  ctrl_o.branch = riscv_isa_pkg::BR_GEU;
                    default: ctrl_o.branch = riscv_isa_pkg::BR_NONE;
                endcase
            end
            riscv_isa_pkg::OPC_LOAD: begin
                ctrl_o.rd         = instr_i[11:7];
                ctrl_o.rs1        = instr_i[19:15];
                ctrl_o.reg_we     = 1'b1;
                ctrl_o.mem_read   = 1'b1;
                ctrl_o.mem_to_reg = 1'b1;
                ctrl_o.b_is_imm   = 1'b1;
                ctrl_o.mem_type   = riscv_isa_pkg::mem_type_e'(funct3);
                imm_o             = imm_i_type;
            end
            riscv_isa_pkg::OPC_STORE: begin
                // Address from rs1 + S immediate, data from rs2
                ctrl_o.rs1      = instr_i[19:15];
                ctrl_o.rs2      = instr_i[24:20];
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.mem_type = riscv_isa_pkg::mem_type_e'(funct3);
                imm_o           = imm_s_type;
            end
            riscv_isa_pkg::OPC_OP_IMM: begin
                // Only the shift right uses instr[30]; ADDI has no SUB form
                ctrl_o.rd       = instr_i[11:7];
                ctrl_o.rs1      = instr_i[19:15];
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.alu_op   = alu_from_funct(funct3, instr_i[30] & (funct3 == 3'b101));
                imm_o           = imm_i_type;
            end
            riscv_isa_pkg::OPC_OP: begin
                ctrl_o.rd     = instr_i[11:7];
                ctrl_o.rs1    = instr_i[19:15];
                ctrl_o.rs2    = instr_i[24:20];
                ctrl_o.reg_we = 1'b1;
                ctrl_o.alu_op = alu_from_funct(funct3, instr_i[30]);
            end
            default: begin
                // Unknown opcode, control word stays cleared
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule

//--- source/register_file.sv
module register_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                           clk,
    input  logic                           rst_i,
    input  pipeline_pkg::wb_write_t        wb_i,
    output logic [riscv_isa_pkg::XLEN-1:0] regs_o [NUM_REGS]
);

    // Architectural state
    logic [riscv_isa_pkg::XLEN-1:0] regs_q [NUM_REGS];

    //////////////////////////////////////////////////
    // Write from writeback
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            // Start at 1 so x0 is never written
            // Addresses past NUM_REGS match no entry and are dropped
            for (int i = 1; i < NUM_REGS; i++) begin
                if (wb_i.we && (wb_i.addr == riscv_isa_pkg::REG_ADDR_W'(i))) begin
                    regs_q[i] <= wb_i.data;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Flat view for the read ports
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            regs_o[i] = regs_q[i];
        end
        // Hardwired zero
        regs_o[0] = '0;
    end

endmodule

//--- source/operand_read_port.sv
module operand_read_port #(
    parameter int NUM_REGS = 32
) (
    input  logic [riscv_isa_pkg::XLEN-1:0]       regs_i [NUM_REGS],
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] sel_i,
    input  pipeline_pkg::wb_write_t              wb_i,
    output logic [riscv_isa_pkg::XLEN-1:0]       data_o
);

    // Index width into the implemented registers, 5 for RV32I, 4 for RV32E
    localparam int IDX_W = $clog2(NUM_REGS);

    logic sel_in_range;
    logic wb_hit;

    // Select points at a real, nonzero register
    assign sel_in_range = (sel_i != '0) && (32'(sel_i) < NUM_REGS);

    // Writeback to the same register this cycle
    assign wb_hit = wb_i.we && (wb_i.addr == sel_i);

    always_comb begin
        if (!sel_in_range) begin
            data_o = '0;
        end else if (wb_hit) begin
            // Bypass, storage only updates at the coming edge
            data_o = wb_i.data;
        end else begin
            data_o = regs_i[sel_i[IDX_W-1:0]];
        end
    end

endmodule

//--- source/id_ex_register.sv
module id_ex_register (
    input  logic                           clk,
    input  logic                           rst_i,
    input  pipeline_pkg::decode_ctrl_t     ctrl_i,
    input  logic [riscv_isa_pkg::XLEN-1:0] imm_i,
    input  logic [riscv_isa_pkg::XLEN-1:0] rs1_data_i,
    input  logic [riscv_isa_pkg::XLEN-1:0] rs2_data_i,
    input  logic                           illegal_i,
    input  logic [riscv_isa_pkg::XLEN-1:0] pc_plus4_i,
    input  logic                           predicted_taken_i,
    input  logic                           bubble_i,
    output pipeline_pkg::id_ex_t           id_ex_o
);

    // Control state
    logic                       valid_q;
    logic                       illegal_q;
    pipeline_pkg::decode_ctrl_t ctrl_q;

    // Payload
    logic [riscv_isa_pkg::XLEN-1:0] op_a_q;
    logic [riscv_isa_pkg::XLEN-1:0] op_b_q;
    logic [riscv_isa_pkg::XLEN-1:0] store_data_q;
    logic [riscv_isa_pkg::XLEN-1:0] pc_plus4_q;
    logic                           predicted_taken_q;

    // Operand B select
    logic [riscv_isa_pkg::XLEN-1:0] op_b;
    assign op_b = ctrl_i.b_is_imm ? imm_i : rs2_data_i;

    //////////////////////////////////////////////////
    // Control, bubble clears the word
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
            ctrl_q    <= '0;
        end else begin
            valid_q   <= !bubble_i && !illegal_i;
            // A bubble squashes the slot, so no illegal flag either
            illegal_q <= illegal_i && !bubble_i;
            ctrl_q    <= bubble_i ? '0 : ctrl_i;
        end
    end

    //////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        op_a_q            <= rs1_data_i;
        op_b_q            <= op_b;
        // Stores always take the raw rs2 value
        store_data_q      <= rs2_data_i;
        pc_plus4_q        <= pc_plus4_i;
        predicted_taken_q <= predicted_taken_i;
    end

    assign id_ex_o = '{
        valid:           valid_q,
        ctrl:            ctrl_q,
        op_a:            op_a_q,
        op_b:            op_b_q,
        store_data:      store_data_q,
        pc_plus4:        pc_plus4_q,
        predicted_taken: predicted_taken_q,
        illegal:         illegal_q
    };

endmodule

//--- source/decode_stage.sv
module decode_stage #(
    parameter int NUM_REGS = 32
) (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic [riscv_isa_pkg::XLEN-1:0] instr_i,
    input  logic [riscv_isa_pkg::XLEN-1:0] pc_plus4_i,
    input  logic                           predicted_taken_i,
    input  logic                           bubble_i,
    input  pipeline_pkg::wb_write_t        wb_i,
    output pipeline_pkg::id_ex_t           id_ex_o
);

    // Two read ports, rs1 and rs2
    localparam int NUM_PORTS = 2;

    pipeline_pkg::decode_ctrl_t     ctrl;
    logic [riscv_isa_pkg::XLEN-1:0] imm;
    logic                           illegal;

    logic [riscv_isa_pkg::XLEN-1:0]       regs     [NUM_REGS];
    logic [riscv_isa_pkg::REG_ADDR_W-1:0] rd_sel   [NUM_PORTS];
    logic [riscv_isa_pkg::XLEN-1:0]       rd_data  [NUM_PORTS];

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    rv32i_decoder decoder0 (
        .instr_i   (instr_i),
        .ctrl_o    (ctrl),
        .imm_o     (imm),
        .illegal_o (illegal)
    );

    //////////////////////////////////////////////////
    // Register storage and read ports
    //////////////////////////////////////////////////

    register_file #(
        .NUM_REGS (NUM_REGS)
    ) regfile0 (
        .clk    (clk),
        .rst_i  (rst_i),
        .wb_i   (wb_i),
        .regs_o (regs)
    );

    // Port 0 reads rs1, port 1 reads rs2
    assign rd_sel[0] = ctrl.rs1;
    assign rd_sel[1] = ctrl.rs2;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_read_port
        operand_read_port #(
            .NUM_REGS (NUM_REGS)
        ) port (
            .regs_i (regs),
            .sel_i  (rd_sel[p]),
            .wb_i   (wb_i),
            .data_o (rd_data[p])
        );
    end

    //////////////////////////////////////////////////
    // ID/EX pipeline register
    //////////////////////////////////////////////////

    id_ex_register id_ex0 (
        .clk               (clk),
        .rst_i             (rst_i),
        .ctrl_i            (ctrl),
        .imm_i             (imm),
        .rs1_data_i        (rd_data[0]),
        .rs2_data_i        (rd_data[1]),
        .illegal_i         (illegal),
        .pc_plus4_i        (pc_plus4_i),
        .predicted_taken_i (predicted_taken_i),
        .bubble_i          (bubble_i),
        .id_ex_o           (id_ex_o)
    );

endmodule

//--- bench/tb_decode_stage.sv
module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_REGS = 32;
    localparam int XLEN = riscv_isa_pkg::XLEN;
    localparam int CHK_W = $bits(pipeline_pkg::id_ex_t);

    // Test lengths in cycles for the watchdog
    localparam int RESET_CYCLES = 8;
    localparam int N_ALU = 40;
    localparam int N_MEM = 30;
    localparam int N_BRANCH = 24;
    localparam int N_DIRECTED = 32;
    localparam int TOTAL_CYCLES = RESET_CYCLES + N_ALU + N_MEM + N_BRANCH + N_DIRECTED;

    // Legal funct3 values indexed by random bits
    localparam logic [2:0] LOAD_F3 [8] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd2, 3'd0, 3'd4};
    localparam logic [2:0] STORE_F3 [4] = '{3'd0, 3'd1, 3'd2, 3'd2};
    localparam logic [2:0] BRANCH_F3 [8] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7, 3'd0, 3'd1};

    logic                    clk;
    logic                    rst_i;
    logic [XLEN-1:0]         instr_i;
    logic [XLEN-1:0]         pc_plus4_i;
    logic                    predicted_taken_i;
    logic                    bubble_i;
    pipeline_pkg::wb_write_t wb_i;
    pipeline_pkg::id_ex_t    id_ex_o;

    // Register model, expectations and their test names
    logic [XLEN-1:0]      reg_model [NUM_REGS];
    pipeline_pkg::id_ex_t exp_q [$];
    string                name_q [$];
    logic [31:0]          rng_state;

    decode_stage #(
        .NUM_REGS (NUM_REGS)
    ) dut0 (
        .clk               (clk),
        .rst_i             (rst_i),
        .instr_i           (instr_i),
        .pc_plus4_i        (pc_plus4_i),
        .predicted_taken_i (predicted_taken_i),
        .bubble_i          (bubble_i),
        .wb_i              (wb_i),
        .id_ex_o           (id_ex_o)
    );

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [CHK_W-1:0] expected,
                               input logic [CHK_W-1:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // Xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic pipeline_pkg::wb_write_t write_of(input logic [4:0] addr,
                                                         input logic [XLEN-1:0] data);
        return '{we: 1'b1, addr: addr, data: data};
    endfunction

    function automatic pipeline_pkg::wb_write_t rand_wb();
        logic [31:0] r;
        r = next_rand();
        return '{we: r[0], addr: r[5:1], data: next_rand()};
    endfunction

    // Register read as the EX stage should see it
    // A same-cycle writeback wins
    function automatic logic [XLEN-1:0] read_model(input logic [4:0] sel,
                                                   input pipeline_pkg::wb_write_t wb);
        if (sel == 5'd0) begin
            return '0;
        end
        if (wb.we && wb.addr == sel) begin
            return wb.data;
        end
        return reg_model[sel];
    endfunction

    function automatic riscv_isa_pkg::alu_op_e alu_for(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? riscv_isa_pkg::ALU_SUB : riscv_isa_pkg::ALU_ADD;
            3'd1:    return riscv_isa_pkg::ALU_SLL;
            3'd2:    return riscv_isa_pkg::ALU_SLT;
            3'd3:    return riscv_isa_pkg::ALU_SLTU;
            3'd4:    return riscv_isa_pkg::ALU_XOR;
            3'd5:    return alt ? riscv_isa_pkg::ALU_SRA : riscv_isa_pkg::ALU_SRL;
            3'd6:    return riscv_isa_pkg::ALU_OR;
            default: return riscv_isa_pkg::ALU_AND;
        endcase
    endfunction

    function automatic riscv_isa_pkg::branch_e branch_for(input logic [2:0] f3);
        case (f3)
            3'd0:    return riscv_isa_pkg::BR_EQ;
            3'd1:    return riscv_isa_pkg::BR_NE;
            3'd4:    return riscv_isa_pkg::BR_LT;
            3'd5:    return riscv_isa_pkg::BR_GE;
            3'd6:    return riscv_isa_pkg::BR_LTU;
            3'd7:    return riscv_isa_pkg::BR_GEU;
            default: return riscv_isa_pkg::BR_NONE;
        endcase
    endfunction

    // Access size by load and store funct3
    function automatic riscv_isa_pkg::mem_type_e mem_type_for(input logic [2:0] f3);
        case (f3)
            3'd0:    return riscv_isa_pkg::MEM_BYTE;
            3'd1:    return riscv_isa_pkg::MEM_HALF;
            3'd4:    return riscv_isa_pkg::MEM_BYTE_U;
            3'd5:    return riscv_isa_pkg::MEM_HALF_U;
            default: return riscv_isa_pkg::MEM_WORD;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Reference model of one decode slot
    //////////////////////////////////////////////////

    function automatic pipeline_pkg::id_ex_t expect_id_ex(
        input logic [XLEN-1:0] instr, input logic [XLEN-1:0] pc4, input logic pt,
        input logic bubble, input pipeline_pkg::wb_write_t wb
    );
        pipeline_pkg::id_ex_t e;
        logic [6:0]           opc;
        logic [2:0]           f3;
        logic                 known;
        logic [XLEN-1:0]      imm;
        logic [XLEN-1:0]      rs2_val;
        e = '0;
        imm = '0;
        known = 1'b1;
        opc = instr[6:0];
        f3 = instr[14:12];
        // Immediate by instruction format
        case (opc)
            riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC:
                imm = {instr[31:12], 12'h000};
            riscv_isa_pkg::OPC_JAL:
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            riscv_isa_pkg::OPC_JALR, riscv_isa_pkg::OPC_LOAD, riscv_isa_pkg::OPC_OP_IMM:
                imm = {{20{instr[31]}}, instr[31:20]};
            riscv_isa_pkg::OPC_STORE:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            riscv_isa_pkg::OPC_BRANCH:
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            riscv_isa_pkg::OPC_OP:
                imm = '0;
            default:
                known = 1'b0;
        endcase
        if (known) begin
            // Every format but S and B writes rd
            if (opc != riscv_isa_pkg::OPC_BRANCH && opc != riscv_isa_pkg::OPC_STORE) begin
                e.ctrl.rd = instr[11:7];
                e.ctrl.reg_we = 1'b1;
            end
            // U and J have no rs1
            if (opc != riscv_isa_pkg::OPC_LUI && opc != riscv_isa_pkg::OPC_AUIPC &&
                opc != riscv_isa_pkg::OPC_JAL) begin
                e.ctrl.rs1 = instr[19:15];
            end
            if (opc == riscv_isa_pkg::OPC_OP || opc == riscv_isa_pkg::OPC_STORE ||
                opc == riscv_isa_pkg::OPC_BRANCH) begin
                e.ctrl.rs2 = instr[24:20];
            end
            e.ctrl.b_is_imm = (opc != riscv_isa_pkg::OPC_OP) &&
                              (opc != riscv_isa_pkg::OPC_BRANCH);
            if (opc == riscv_isa_pkg::OPC_LOAD) begin
                e.ctrl.mem_read = 1'b1;
                e.ctrl.mem_to_reg = 1'b1;
            end
            if (opc == riscv_isa_pkg::OPC_LOAD || opc == riscv_isa_pkg::OPC_STORE) begin
                e.ctrl.mem_type = mem_type_for(f3);
            end
            if (opc == riscv_isa_pkg::OPC_JAL || opc == riscv_isa_pkg::OPC_JALR) begin
                e.ctrl.branch = riscv_isa_pkg::BR_JUMP;
            end
            if (opc == riscv_isa_pkg::OPC_BRANCH) begin
                e.ctrl.branch = branch_for(f3);
                e.ctrl.alu_op = riscv_isa_pkg::ALU_SUB;
            end
            // Immediate shifts use bit 30 for SRAI
            // ADDI has no subtract form
            if (opc == riscv_isa_pkg::OPC_OP || opc == riscv_isa_pkg::OPC_OP_IMM) begin
                e.ctrl.alu_op = alu_for(f3, instr[30] &&
                                        (opc == riscv_isa_pkg::OPC_OP || f3 == 3'd5));
            end
            if (opc == riscv_isa_pkg::OPC_LUI) begin
                e.ctrl.alu_op = riscv_isa_pkg::ALU_PASS_B;
            end
        end
        rs2_val = read_model(e.ctrl.rs2, wb);
        e.op_a = read_model(e.ctrl.rs1, wb);
        e.op_b = e.ctrl.b_is_imm ? imm : rs2_val;
        e.store_data = rs2_val;
        e.pc_plus4 = pc4;
        e.predicted_taken = pt;
        e.valid = known && !bubble;
        e.illegal = !known && !bubble;
        // Bubble squashes the control word while operands still flow
        if (bubble) begin
            e.ctrl = '0;
        end
        return e;
    endfunction

    // Drive one slot on the falling edge and queue its expectation
    task automatic issue(input string name, input logic [XLEN-1:0] instr, input logic bubble,
                         input pipeline_pkg::wb_write_t wb);
        logic [31:0] pc4;
        logic [31:0] r;
        pc4 = next_rand() & 32'hffff_fffc;
        r = next_rand();
        @(negedge clk);
        instr_i = instr;
        pc_plus4_i = pc4;
        predicted_taken_i = r[0];
        bubble_i = bubble;
        wb_i = wb;
        exp_q.push_back(expect_id_ex(instr, pc4, r[0], bubble, wb));
        name_q.push_back(name);
        // Storage takes the write at the coming edge
        if (wb.we && wb.addr != 5'd0) begin
            reg_model[wb.addr] = wb.data;
        end
    endtask

    //////////////////////////////////////////////////
    // Clock, watchdog, compare
    //////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #((TOTAL_CYCLES + 50) * 10);
        $display("Timeout, the tests did not finish in the expected time");
        $display("sim failed");
        $fatal(1);
    end

    // Output settles just after the edge that captured the slot
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (exp_q.size() > 0) begin
                check_value(name_q.pop_front(), exp_q.pop_front(), id_ex_o);
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [31:0] instr;
        rng_state = 32'h15b351d0;
        rst_i = 1'b1;
        // A legal ADD sits at the input during reset
        // Only the reset keeps it out of the ID/EX register
        instr_i = encode_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, riscv_isa_pkg::OPC_OP);
        pc_plus4_i = '0;
        predicted_taken_i = 1'b0;
        bubble_i = 1'b0;
        wb_i = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            reg_model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        check_value("reset_valid", '0, CHK_W'(id_ex_o.valid));
        check_value("reset_ctrl", '0, CHK_W'(id_ex_o.ctrl));

        // All registers read zero and x0 ignores writes
        for (int i = 0; i < NUM_REGS; i += 2) begin
            instr = encode_r(7'h00, 5'(i + 1), 5'(i), 3'd0, 5'd1, riscv_isa_pkg::OPC_OP);
            issue("reset_regs", instr, 1'b0, '0);
        end
        instr = encode_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd2, riscv_isa_pkg::OPC_OP);
        issue("x0_write", instr, 1'b0, write_of(5'd0, 32'h1234_5678));
        issue("x0_after", instr, 1'b0, '0);

        // Random register and immediate ALU forms
        for (int n = 0; n < N_ALU; n++) begin
            r = next_rand();
            instr = next_rand();
            instr[6:0] = r[0] ? riscv_isa_pkg::OPC_OP : riscv_isa_pkg::OPC_OP_IMM;
            issue("alu_decode", instr, 1'b0, rand_wb());
        end

        // Loads, stores, upper immediates, JAL
        for (int n = 0; n < N_MEM; n++) begin
            r = next_rand();
            instr = next_rand();
            case (r[2:0])
                3'd0, 3'd5: begin
                    instr[6:0] = riscv_isa_pkg::OPC_LOAD;
                    instr[14:12] = LOAD_F3[r[10:8]];
                end
                3'd1, 3'd6: begin
                    instr[6:0] = riscv_isa_pkg::OPC_STORE;
                    instr[14:12] = STORE_F3[r[12:11]];
                end
                3'd2, 3'd7: instr[6:0] = riscv_isa_pkg::OPC_LUI;
                3'd3:       instr[6:0] = riscv_isa_pkg::OPC_AUIPC;
                default:    instr[6:0] = riscv_isa_pkg::OPC_JAL;
            endcase
            issue("mem_upper_jump", instr, 1'b0, rand_wb());
        end

        // Conditional branches and jumps
        for (int n = 0; n < N_BRANCH; n++) begin
            r = next_rand();
            instr = next_rand();
            case (r[2:0])
                3'd6:    instr[6:0] = riscv_isa_pkg::OPC_JAL;
                3'd7:    instr[6:0] = riscv_isa_pkg::OPC_JALR;
                default: begin
                    instr[6:0] = riscv_isa_pkg::OPC_BRANCH;
                    instr[14:12] = BRANCH_F3[r[2:0]];
                end
            endcase
            issue("branch_decode", instr, 1'b0, rand_wb());
        end

        // Same-cycle writeback bypass and then the stored copy
        instr = encode_r(7'h00, 5'd6, 5'd5, 3'd0, 5'd9, riscv_isa_pkg::OPC_OP);
        issue("bypass_rs1", instr, 1'b0, write_of(5'd5, 32'hcafe_0005));
        issue("stored_rs1", instr, 1'b0, '0);
        issue("bypass_rs2", instr, 1'b0, write_of(5'd6, 32'hbeef_0006));
        issue("stored_rs2", instr, 1'b0, '0);
        instr = encode_r(7'h12, 5'd7, 5'd7, 3'd2, 5'd3, riscv_isa_pkg::OPC_STORE);
        issue("bypass_both", instr, 1'b0, write_of(5'd7, 32'h0bad_f00d));
        issue("stored_both", instr, 1'b0, '0);

        // Bubbles and undefined opcodes
        instr = next_rand();
        instr[6:0] = riscv_isa_pkg::OPC_OP;
        issue("bubble_op", instr, 1'b1, rand_wb());
        instr[6:0] = riscv_isa_pkg::OPC_LOAD;
        issue("bubble_load", instr, 1'b1, '0);
        instr[6:0] = 7'b0001111;
        issue("illegal_opcode", instr, 1'b0, rand_wb());
        instr[6:0] = 7'b1111111;
        issue("illegal_opcode", instr, 1'b0, '0);
        instr[6:0] = riscv_isa_pkg::OPC_OP_IMM;
        issue("after_illegal", instr, 1'b0, '0);

        // Let the last slot reach the compare
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        $display("sim passed");
        $finish;
    end

endmodule

//--- compile.f
source/riscv_isa_pkg.sv
source/pipeline_pkg.sv
source/rv32i_decoder.sv
source/register_file.sv
source/operand_read_port.sv
source/id_ex_register.sv
source/decode_stage.sv
bench/tb_decode_stage.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0 -Wno-fatal
TOP       := tb_decode_stage
FILELIST  := compile.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf $(BUILD_DIR)
